// File: hw/colmix_pkg.sv
/*
 * Shared types and constants of the palette colour mixer.
 * Palette entries are 15-bit BGR555 kept as two bytes, bit 15 unused.
 * Pixel enables must arrive at least PIX_PERIOD_MIN clocks apart.
 */
`default_nettype none

package colmix_pkg;

    // Palette address, one byte per location
    localparam int PAL_AW = 8;
    localparam int PAL_DEPTH = 1 << PAL_AW;

    // Colour index from the graphics side, one per palette entry pair
    localparam int IDX_W = 7;

    // Bits per colour channel
    localparam int COL_W = 5;

    // Fewest clocks between two pixel enables
    localparam int PIX_PERIOD_MIN = 4;

    // Pixel stages in the blanking line
    localparam int BLANK_DLY = 2;

    // Index sample to colour at the outputs, in pixel enables
    localparam int PIPE_PXL = BLANK_DLY + 1;

    typedef logic [7:0]       pal_byte_t;
    typedef logic [IDX_W-1:0] pal_idx_t;

    // Blue in the top bits, same order as the stored palette word
    typedef struct packed {
        logic [COL_W-1:0] blue;
        logic [COL_W-1:0] green;
        logic [COL_W-1:0] red;
    } rgb_t;

    // CPU side inputs, an access needs cs and cen together
    typedef struct packed {
        logic              cs;
        logic              rnw;
        logic              cen;
        logic [PAL_AW-1:0] addr;
        pal_byte_t         wdata;
    } cpu_bus_t;

    typedef enum logic [1:0] {PH_IDLE, PH_HIGH, PH_LOW, PH_DONE} fetch_phase_t;

endpackage

`default_nettype wire

// File: hw/palette_ram.sv
/*
 * Dual-port palette memory, 256 bytes, no reset on the contents.
 * CPU port writes and reads with one clock latency, no wait states.
 * Lowest CPU address bit is inverted, so even CPU bytes sit in odd locations.
 * Video port is read only, one clock latency, sees CPU writes a cycle later.
 */
`default_nettype none

module palette_ram (
    input  logic                          clk,
    input  logic                          rst,
    input  colmix_pkg::cpu_bus_t          cpu,
    output colmix_pkg::pal_byte_t         pal_dout,
    input  logic [colmix_pkg::PAL_AW-1:0] vid_addr,
    output colmix_pkg::pal_byte_t         vid_data
);
    import colmix_pkg::*;

    // Storage, indexed by physical location
    pal_byte_t mem [PAL_DEPTH];

    // Physical location of the CPU access
    logic [PAL_AW-1:0] cpu_loc;

    // Access qualifiers
    logic cpu_acc;
    logic cpu_we;
    logic cpu_re;

    // Even CPU byte is the high half of an entry,
    // video reads it with the half bit set
    assign cpu_loc = {cpu.addr[PAL_AW-1:1], ~cpu.addr[0]};

    assign cpu_acc = cpu.cs & cpu.cen;
    assign cpu_we  = cpu_acc & ~cpu.rnw;
    assign cpu_re  = cpu_acc & cpu.rnw;

    // CPU write port
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_loc] <= cpu.wdata;
        end
    end

    // CPU read data, held until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            pal_dout <= '0;
        end else if (cpu_re) begin
            pal_dout <= mem[cpu_loc];
        end
    end

    // Video read port
    // Old data when the CPU writes the same location this cycle
    always_ff @(posedge clk) begin
        vid_data <= mem[vid_addr];
    end

    // Address must be clean whenever the CPU actually accesses
    a_cpu_addr_known: assert property (
        @(posedge clk) disable iff (rst)
        (cpu.cs && cpu.cen) |-> !$isunknown(cpu.addr)
    ) else $error("palette_ram: unknown CPU address during access");

endmodule

`default_nettype wire

// File: hw/colour_fetch.sv
/*
 * Per-pixel palette fetch: samples the index on pxl_cen, reads the high and
 * then the low byte, and hands the joined colour out on the next pxl_cen.
 * Needs pxl_cen at least PIX_PERIOD_MIN clocks apart, two pixels in flight.
 * Bit 15 of the palette word is dropped.
 */
`default_nettype none

module colour_fetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  colmix_pkg::pal_idx_t          gfx_pxl,
    output logic [colmix_pkg::PAL_AW-1:0] vid_addr,
    input  colmix_pkg::pal_byte_t         vid_data,
    output colmix_pkg::rgb_t              col
);
    import colmix_pkg::*;

    fetch_phase_t state;

    // Index of the pixel being fetched
    pal_idx_t idx;

    // Palette word being assembled, high byte first
    logic [15:0] col_word;

    // Half bit 1 selects the high byte
    logic half_hi;

    assign half_hi  = (state == PH_HIGH);
    assign vid_addr = {idx, half_hi};

    // Phase sequencer
    // pxl_cen always restarts the fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PH_IDLE;
        end else if (pxl_cen) begin
            state <= PH_HIGH;
        end else begin
            case (state)
                PH_HIGH: begin
                    state <= PH_LOW;
                end
                PH_LOW: begin
                    state <= PH_DONE;
                end
                PH_DONE: begin
                    state <= PH_IDLE;
                end
                default: begin
                    state <= PH_IDLE;
                end
            endcase
        end
    end

    // Index capture and colour hand-off
    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
            col <= '0;
        end else if (pxl_cen) begin
            idx <= gfx_pxl;
            // Previous pixel's word, complete by now
            col <= rgb_t'(col_word[14:0]);
        end
    end

    // Byte capture
    // RAM answers one cycle after the address, so each byte lands a phase late
    always_ff @(posedge clk) begin
        if (rst) begin
            col_word <= '0;
        end else begin
            if (state == PH_LOW) begin
                col_word[15:8] <= vid_data;
            end
            if (state == PH_DONE) begin
                col_word[7:0] <= vid_data;
            end
        end
    end

    // A new pixel must not cut a fetch short
    a_no_cen_mid_fetch: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |-> !(state inside {PH_HIGH, PH_LOW})
    ) else $error("colour_fetch: pxl_cen during palette fetch");

    // Minimum pixel period
    a_pxl_period: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen [* (PIX_PERIOD_MIN - 1)]
    ) else $error("colour_fetch: pxl_cen closer than PIX_PERIOD_MIN");

endmodule

`default_nettype wire

// File: hw/blank_delay.sv
/*
 * Blanking and colour delay line, advancing only on pxl_cen.
 * col_in is already one pixel behind its blanking, so the blanking line
 * carries one stage more than the DLY colour stages. DLY must be 1 or more.
 * rgb is forced black while either delayed blanking bit is low.
 */
`default_nettype none

module blank_delay #(
    parameter int DLY = colmix_pkg::BLANK_DLY
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             pxl_cen,
    input  logic             lhbl,
    input  logic             lvbl,
    input  colmix_pkg::rgb_t col_in,
    output logic             lhbl_dly,
    output logic             lvbl_dly,
    output colmix_pkg::rgb_t rgb
);
    import colmix_pkg::*;

    // Blanking lines, bit 0 is the newest
    logic [DLY:0] hbl_line;
    logic [DLY:0] vbl_line;

    // Colour line, entry 0 is the newest
    rgb_t col_line [DLY];

    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_line <= '0;
            vbl_line <= '0;
            for (int i = 0; i < DLY; i++) begin
                col_line[i] <= '0;
            end
        end else if (pxl_cen) begin
            hbl_line <= {hbl_line[DLY-1:0], lhbl};
            vbl_line <= {vbl_line[DLY-1:0], lvbl};
            col_line[0] <= col_in;
            for (int i = 1; i < DLY; i++) begin
                col_line[i] <= col_line[i-1];
            end
        end
    end

    // Last stage drives the outputs
    assign lhbl_dly = hbl_line[DLY];
    assign lvbl_dly = vbl_line[DLY];

    // Black during either blanking
    assign rgb = (lhbl_dly && lvbl_dly) ? col_line[DLY-1] : '0;

    // Outputs only move on the edge that follows a pixel enable
    a_hold_between_cen: assert property (
        @(posedge clk) disable iff (rst)
        (!$past(pxl_cen) && !$past(rst)) |-> $stable({lhbl_dly, lvbl_dly, rgb})
    ) else $error("blank_delay: output changed without pxl_cen");

endmodule

`default_nettype wire

// File: hw/colour_mixer.sv
/*
 * Colour mixer top: palette RAM, per-pixel fetch and blanking delay.
 * Single clock, CPU strobes through cpu.cen, video through pxl_cen.
 * Colour for an index appears PIPE_PXL pixel enables after it is sampled.
 */
`default_nettype none

module colour_mixer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  lhbl,
    input  logic                  lvbl,
    input  colmix_pkg::cpu_bus_t  cpu,
    input  colmix_pkg::pal_idx_t  gfx_pxl,
    output colmix_pkg::pal_byte_t pal_dout,
    output logic                  lhbl_dly,
    output logic                  lvbl_dly,
    output colmix_pkg::rgb_t      rgb
);
    import colmix_pkg::*;

    // Video side of the palette
    logic [PAL_AW-1:0] vid_addr;
    pal_byte_t         vid_data;

    // Joined colour, one pixel behind the index
    rgb_t col;

    palette_ram palette_ram_inst (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .pal_dout (pal_dout),
        .vid_addr (vid_addr),
        .vid_data (vid_data)
    );

    colour_fetch colour_fetch_inst (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .gfx_pxl  (gfx_pxl),
        .vid_addr (vid_addr),
        .vid_data (vid_data),
        .col      (col)
    );

    // Blanking and colour line
    blank_delay #(
        .DLY (BLANK_DLY)
    ) blank_delay_inst (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .col_in   (col),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .rgb      (rgb)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
/*
 * Clock and reset source for the testbench.
 * Period 10, rst high until the third rising edge, released by a
 * non-blocking update on that edge.
 */
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD = 5;
    localparam int RST_CYCLES = 3;

    // Free running clock
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset held for the first few edges
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/colour_mixer_tb.sv
/*
 * Testbench for colour_mixer, stimulus and expected values from the vector file.
 * Every vector takes one 4-clock slot with pxl_cen in its first clock.
 * Bus vectors send a blanked filler pixel, so the pixel cadence never breaks.
 * Blanking is driven one pixel after its index, as the video side does.
 */
`default_nettype none

module colour_mixer_tb;
    import colmix_pkg::*;

    localparam VEC_FILE = "testbench/colmix_vectors.txt";
    localparam int SLOT_CLKS = PIX_PERIOD_MIN;
    localparam logic [31:0] LCG_SEED = 32'h7d32_6d2d;

    // One vector line, kind is the ASCII letter W, R, P or I for idle
    typedef struct packed {
        logic [7:0]        kind;
        logic [15:0]       num;
        logic [PAL_AW-1:0] addr;
        pal_byte_t         data;
        pal_idx_t          idx;
        logic              lhbl;
        logic              lvbl;
        rgb_t              rgb;
        logic              lhbl_dly;
        logic              lvbl_dly;
    } vec_t;

    // Expected outputs of one issued pixel
    typedef struct packed {
        logic [15:0] num;
        logic        filler;
        rgb_t        rgb;
        logic [1:0]  blank;
    } exp_pix_t;

    logic      clk;
    logic      rst;
    logic      pxl_cen;
    logic      lhbl;
    logic      lvbl;
    cpu_bus_t  cpu;
    pal_idx_t  gfx_pxl;
    pal_byte_t pal_dout;
    logic      lhbl_dly;
    logic      lvbl_dly;
    rgb_t      rgb;

    vec_t        vecs[$];
    exp_pix_t    exp_q[$];
    logic        loaded;
    logic [31:0] lcg_state;

    // Blanking of the previous pixel, driven with the next index
    logic prev_lhbl;
    logic prev_lvbl;

    tb_clock clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    colour_mixer colour_mixer_inst (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .cpu      (cpu),
        .gfx_pxl  (gfx_pxl),
        .pal_dout (pal_dout),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .rgb      (rgb)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_byte(input string name, input pal_byte_t exp, input pal_byte_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s pal_dout expected %h actual %h",
                                     name, exp, act));
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s rgb expected %h actual %h", name, exp, act));
        end
    endtask

    // Bit 1 is lhbl_dly, bit 0 is lvbl_dly
    task automatic check_blank(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s blanking expected %b actual %b",
                                     name, exp, act));
        end
    endtask

    // Whole file into vecs, comment lines start with a lone #
    task automatic load_vectors();
        int               fd;
        int               n;
        logic [7:0]       op;
        logic [31:0]      f1, f2, f3, f4, f5, f6;
        logic [8*128-1:0] rest;
        vec_t             v;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            report_failure($sformatf("could not open the vector file %s", VEC_FILE));
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            v = '0;
            v.kind = op;
            v.num = 16'(vecs.size() + 1);
            if (op == "#") begin
                n = $fgets(rest, fd);
            end else if (op == "W" || op == "R") begin
                n = $fscanf(fd, "%h %h", f1, f2);
                if (n != 2) begin
                    report_failure("vector file has a bus line with missing fields");
                end
                v.addr = f1[PAL_AW-1:0];
                v.data = f2[7:0];
                vecs.push_back(v);
            end else if (op == "P") begin
                n = $fscanf(fd, "%h %h %h %h %h %h", f1, f2, f3, f4, f5, f6);
                if (n != 6) begin
                    report_failure("vector file has a pixel line with missing fields");
                end
                v.idx      = f1[IDX_W-1:0];
                v.lhbl     = f2[0];
                v.lvbl     = f3[0];
                v.rgb      = rgb_t'(f4[3*COL_W-1:0]);
                v.lhbl_dly = f5[0];
                v.lvbl_dly = f6[0];
                vecs.push_back(v);
            end else begin
                report_failure($sformatf("vector file has an unknown line kind %s", op));
            end
        end
        $fclose(fd);
    endtask

    // One pixel slot, with the bus access of W and R vectors in its second clock
    task automatic run_slot(input vec_t v);
        pal_idx_t idx;
        logic     hb;
        logic     vb;
        exp_pix_t e;
        exp_pix_t done_pix;
        cpu_bus_t bus;
        string    name;

        if (v.kind == "P") begin
            idx      = v.idx;
            hb       = v.lhbl;
            vb       = v.lvbl;
            e.rgb    = v.rgb;
            e.blank  = {v.lhbl_dly, v.lvbl_dly};
            e.filler = 1'b0;
        end else begin
            // Filler in full blanking, any index must give black
            lcg_state = lcg_next(lcg_state);
            idx       = lcg_state[30:24];
            hb        = 1'b0;
            vb        = 1'b0;
            e.rgb     = '0;
            e.blank   = 2'b00;
            e.filler  = 1'b1;
        end
        e.num = v.num;

        bus = '0;
        if (v.kind == "W" || v.kind == "R") begin
            bus.cs    = 1'b1;
            bus.cen   = 1'b1;
            bus.rnw   = (v.kind == "R");
            bus.addr  = v.addr;
            bus.wdata = (v.kind == "W") ? v.data : 8'h00;
        end

        // New pixel
        @(posedge clk);
        pxl_cen   <= 1'b1;
        gfx_pxl   <= idx;
        lhbl      <= prev_lhbl;
        lvbl      <= prev_lvbl;
        prev_lhbl = hb;
        prev_lvbl = vb;
        exp_q.push_back(e);

        // Bus access, pixel fetch already under way
        @(posedge clk);
        pxl_cen <= 1'b0;
        cpu     <= bus;

        // Access taken on this edge, outputs moved on the previous one
        @(posedge clk);
        cpu <= '0;
        @(negedge clk);
        if (v.kind == "R") begin
            check_byte($sformatf("vector %0d read", v.num), v.data, pal_dout);
        end
        // Front entry was issued PIPE_PXL pixels back
        if (exp_q.size() > PIPE_PXL) begin
            done_pix = exp_q.pop_front();
            if (done_pix.filler) begin
                name = $sformatf("vector %0d idle pixel", done_pix.num);
            end else begin
                name = $sformatf("vector %0d pixel", done_pix.num);
            end
            check_rgb(name, done_pix.rgb, rgb);
            check_blank(name, done_pix.blank, {lhbl_dly, lvbl_dly});
        end
        repeat (SLOT_CLKS - 3) @(posedge clk);
    endtask

    initial begin
        vec_t flush;

        pxl_cen   = 1'b0;
        lhbl      = 1'b0;
        lvbl      = 1'b0;
        gfx_pxl   = '0;
        cpu       = '0;
        loaded    = 1'b0;
        lcg_state = LCG_SEED;
        prev_lhbl = 1'b0;
        prev_lvbl = 1'b0;

        load_vectors();
        loaded = 1'b1;

        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_byte("after reset", 8'h00, pal_dout);
        check_rgb("after reset", '0, rgb);
        check_blank("after reset", 2'b00, {lhbl_dly, lvbl_dly});

        foreach (vecs[i]) begin
            run_slot(vecs[i]);
        end
        // Idle pixels push the last real ones out
        for (int k = 0; k < PIPE_PXL; k++) begin
            flush      = '0;
            flush.kind = "I";
            flush.num  = 16'(vecs.size() + k + 1);
            run_slot(flush);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

    // Watchdog, 16 clocks per vector line plus margin
    initial begin
        wait (loaded === 1'b1);
        repeat (vecs.size() * 16 + 100) @(posedge clk);
        report_failure("the run timed out before all vectors were applied");
    end

endmodule

`default_nettype wire

// File: files.f
hw/colmix_pkg.sv
hw/palette_ram.sv
hw/colour_fetch.sv
hw/blank_delay.sv
hw/colour_mixer.sv
testbench/tb_clock.sv
testbench/colour_mixer_tb.sv

// File: testbench/colmix_vectors.txt
# Columns: W addr data | R addr expected_data | P index lhbl lvbl expected_rgb lhbl_dly lvbl_dly
# All numbers hex, rgb is 15 bits packed blue:green:red, entry i at bytes 2i (high) and 2i+1
W 06 7C
W 07 1F
W 14 FF
W 15 FF
W FE 83
W FF E0
W 80 2A
W 81 55
W 02 01
W 03 23
W 40 D5
W 41 AA
# Read back, odd and even addresses
R 07 1F
R 06 7C
R FF E0
R 81 55
R 14 FF
# Single pixels and a back-to-back run
P 03 1 1 7C1F 1 1
P 0A 1 1 7FFF 1 1
P 7F 1 1 03E0 1 1
P 40 1 1 2A55 1 1
P 01 1 1 0123 1 1
P 20 1 1 55AA 1 1
# Horizontal, vertical and both blanking
P 03 0 1 0000 0 1
P 0A 1 0 0000 1 0
P 7F 0 0 0000 0 0
P 40 1 1 2A55 1 1
# Entry 3 rewritten, later pixels take the new colour
W 06 12
W 07 34
R 06 12
P 03 1 1 1234 1 1
P 01 1 1 0123 1 1
P 03 1 1 1234 1 1
